//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_echo_timer
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= RESULT: PASS

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
src/echo_pkg.sv
src/bus_pkg.sv
src/uart_rx.sv
src/echo_detect.sv
src/burst_tx.sv
src/measure_ctrl.sv
src/timing_accum.sv
src/wb_regs.sv
src/echo_timer_top.sv
tb/echo_timer_assert.sv
tb/tb_echo_timer.sv

//--- src/burst_tx.sv
`timescale 1ns/100ps

module burst_tx import echo_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic frame_start,
    output logic tx_out,
    output logic burst_active
);

    frame_off_t remain;   // cycles left after the current one

    always_ff @(posedge clk) begin
        if (rst) begin
            remain <= '0;
        end else if (frame_start) begin
            remain <= frame_off_t'(burst_len - 1);
        end else if (remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    // pulse starts in the frame_start cycle itself
    assign burst_active = frame_start || (remain != '0);
    assign tx_out       = burst_active;

endmodule

//--- src/bus_pkg.sv
package bus_pkg;

    typedef logic [1:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    // register map
    localparam wb_adr_t reg_status = 2'd0;   // bit0 busy, bit1 done
    localparam wb_adr_t reg_result = 2'd1;
    localparam wb_adr_t reg_runs   = 2'd2;
    localparam wb_adr_t reg_id     = 2'd3;

    localparam wb_dat_t id_value = 32'hEC40_0001;

    localparam int runs_w = 16;   // completed run counter, wraps

endpackage

//--- src/echo_detect.sv
`timescale 1ns/100ps

module echo_detect (
    input  logic clk,
    input  logic rst,
    input  logic echo_in,
    input  logic burst_active,
    output logic echo_stb
);

    logic [2:0] sync;     // sync[2] is the previous settled sample
    logic       rise_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync   <= '0;
            rise_q <= 1'b0;
        end else begin
            sync   <= {sync[1:0], echo_in};
            rise_q <= sync[1] & ~sync[2];
        end
    end

    // our own transmit pulse leaks into the receiver, ignore it
    assign echo_stb = rise_q & ~burst_active;

endmodule

//--- src/echo_pkg.sv
package echo_pkg;

    // run geometry, kept short so a run fits a quick simulation
    localparam int frame_len      = 256;   // cycles per frame
    localparam int frames_per_run = 8;
    localparam int burst_len      = 16;    // tx pulse width in cycles
    localparam int clks_per_bit   = 16;    // uart bit period

    localparam logic [7:0] start_byte = 8'h53;  // ascii 'S'

    typedef logic [7:0]  frame_off_t;   // cycle offset inside a frame
    typedef logic [2:0]  frame_idx_t;   // frame number inside a run
    typedef logic [11:0] edge_sum_t;    // wraps at 4096
    typedef logic [23:0] result_t;      // {begin sum, end sum}

    typedef enum logic [1:0] {
        idle,
        run,
        finish
    } ctrl_state_t;

endpackage

//--- src/echo_timer_top.sv
`timescale 1ns/100ps

module echo_timer_top import echo_pkg::*, bus_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    uart_rxd,
    input  logic    echo_in,
    output logic    tx_out,
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  wb_adr_t wb_adr,
    input  wb_dat_t wb_dat_w,
    output wb_dat_t wb_dat_r,
    output logic    wb_ack
);

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       busy;
    logic       frame_start;
    frame_off_t frame_off;
    logic       run_done;
    logic       burst_active;
    logic       echo_stb;
    result_t    result;
    logic       result_valid;

    uart_rx u_uart_rx (
        .clk   (clk),
        .rst   (rst),
        .rxd   (uart_rxd),
        .data  (rx_byte),
        .valid (rx_valid)
    );

    measure_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .busy        (busy),
        .frame_start (frame_start),
        .frame_off   (frame_off),
        .run_done    (run_done)
    );

    burst_tx u_burst (
        .clk          (clk),
        .rst          (rst),
        .frame_start  (frame_start),
        .tx_out       (tx_out),
        .burst_active (burst_active)
    );

    echo_detect u_echo (
        .clk          (clk),
        .rst          (rst),
        .echo_in      (echo_in),
        .burst_active (burst_active),
        .echo_stb     (echo_stb)
    );

    timing_accum u_accum (
        .clk          (clk),
        .rst          (rst),
        .busy         (busy),
        .frame_start  (frame_start),
        .frame_off    (frame_off),
        .echo_stb     (echo_stb),
        .run_done     (run_done),
        .result       (result),
        .result_valid (result_valid)
    );

    wb_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid),
        .run_start    (frame_start)   // qualified with busy inside
    );

endmodule

//--- src/measure_ctrl.sv
`timescale 1ns/100ps

module measure_ctrl import echo_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    output logic       busy,
    output logic       frame_start,
    output frame_off_t frame_off,
    output logic       run_done
);

    ctrl_state_t state;
    frame_idx_t  frame_idx;
    logic        start_hit;
    logic        frame_end;
    logic        last_frame;

    assign start_hit  = rx_valid && (rx_byte == start_byte);
    assign frame_end  = (frame_off == frame_off_t'(frame_len - 1));
    assign last_frame = (frame_idx == frame_idx_t'(frames_per_run - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            frame_off <= '0;
            frame_idx <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start_hit) begin
                        state     <= run;
                        frame_off <= '0;
                        frame_idx <= '0;
                    end
                end
                run: begin
                    frame_off <= frame_off + 1'b1;   // wraps to 0 at frame end
                    if (frame_end) begin
                        frame_idx <= frame_idx + 1'b1;
                        if (last_frame) begin
                            state <= finish;
                        end
                    end
                end
                finish: begin
                    state <= idle;   // one cycle for run_done
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    assign busy        = (state != idle);
    assign frame_start = (state == run) && (frame_off == '0);
    assign run_done    = (state == finish);

endmodule

//--- src/timing_accum.sv
`timescale 1ns/100ps

module timing_accum import echo_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       busy,
    input  logic       frame_start,
    input  frame_off_t frame_off,
    input  logic       echo_stb,
    input  logic       run_done,
    output result_t    result,
    output logic       result_valid
);

    edge_sum_t  begin_sum;
    edge_sum_t  end_sum;
    edge_sum_t  begin_next;
    edge_sum_t  end_next;
    frame_off_t first_off;
    frame_off_t last_off;
    logic       seen;     // current frame has had an edge
    logic       hit;

    // the finish cycle belongs to no frame
    assign hit = echo_stb && busy && !run_done;

    // sums with the frame that is closing folded in
    always_comb begin
        begin_next = begin_sum;
        end_next   = end_sum;
        if (seen) begin
            begin_next = begin_sum + edge_sum_t'(first_off);
            end_next   = end_sum + edge_sum_t'(last_off);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            begin_sum    <= '0;
            end_sum      <= '0;
            seen         <= 1'b0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= run_done;
            if (!busy) begin
                begin_sum <= '0;   // fresh sums for the next run
                end_sum   <= '0;
                seen      <= 1'b0;
            end else if (frame_start || run_done) begin
                begin_sum <= begin_next;
                end_sum   <= end_next;
                seen      <= hit;
                if (run_done) begin
                    result <= {begin_next, end_next};
                end
            end else if (hit) begin
                seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (!seen || frame_start) begin
                first_off <= frame_off;
            end
            last_off <= frame_off;
        end
    end

endmodule

//--- src/uart_rx.sv
`timescale 1ns/100ps

module uart_rx import echo_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] data,
    output logic       valid
);

    logic [1:0] rxd_sync;
    logic       rx;        // synchronized line
    logic       active;
    logic [3:0] tick;      // counts down to the next sample point
    logic [3:0] bit_n;     // 0 start, 1..8 data, 9 stop
    logic [7:0] shift;

    assign rx = rxd_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_sync <= 2'b11;   // line idles high
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            tick   <= '0;
            bit_n  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (!active) begin
                if (!rx) begin
                    // first low sample, aim at the middle of the start bit
                    active <= 1'b1;
                    tick   <= 4'(clks_per_bit / 2 - 1);
                    bit_n  <= '0;
                end
            end else if (tick != 4'd0) begin
                tick <= tick - 1'b1;
            end else begin
                tick  <= 4'(clks_per_bit - 1);
                bit_n <= bit_n + 1'b1;
                if (bit_n == 4'd0 && rx) begin
                    active <= 1'b0;          // glitch, not a start bit
                end else if (bit_n == 4'd9) begin
                    active <= 1'b0;
                    valid  <= rx;            // bad stop bit drops the byte
                end
            end
        end
    end

    // data bits come in lsb first
    always_ff @(posedge clk) begin
        if (active && tick == 4'd0 && bit_n != 4'd0 && bit_n != 4'd9) begin
            shift <= {rx, shift[7:1]};
        end
    end

    assign data = shift;

endmodule

//--- src/wb_regs.sv
`timescale 1ns/100ps

module wb_regs import echo_pkg::*, bus_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  wb_adr_t wb_adr,
    input  wb_dat_t wb_dat_w,
    output wb_dat_t wb_dat_r,
    output logic    wb_ack,
    input  logic    busy,
    input  result_t result,
    input  logic    result_valid,
    input  logic    run_start
);

    logic              busy_q;
    logic              done;
    logic              new_run;
    logic [runs_w-1:0] runs;
    wb_dat_t           rd_data;

    // only the frame_start that opens a run
    assign new_run = run_start && !busy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            done   <= 1'b0;
            runs   <= '0;
        end else begin
            busy_q <= busy;
            if (new_run) begin
                done <= 1'b0;
            end else if (result_valid) begin
                done <= 1'b1;
            end
            if (result_valid) begin
                runs <= runs + 1'b1;
            end
        end
    end

    always_comb begin
        case (wb_adr)
            reg_status: rd_data = wb_dat_t'({done, busy});
            reg_result: rd_data = wb_dat_t'(result);
            reg_runs:   rd_data = wb_dat_t'(runs);
            reg_id:     rd_data = id_value;
            default:    rd_data = '0;
        endcase
    end

    // single cycle ack, a held request gets one ack per transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    // the register file is read only, write data goes nowhere
    always_ff @(posedge clk) begin
        if (wb_cyc && wb_stb && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

//--- tb/echo_timer_assert.sv
`timescale 1ns/100ps

module echo_timer_assert import echo_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       frame_start,
    input logic       run_done,
    input logic       busy,
    input logic       rx_valid,
    input logic [7:0] rx_byte,
    input logic       wb_stb,
    input logic       wb_ack
);

    frame_marks_apart: assert property (@(posedge clk) disable iff (rst)
        !(frame_start && run_done))
        else $error("frame_start and run_done high in the same cycle");

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack held for more than one cycle");

    ack_needs_stb: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_stb)
        else $error("wb_ack high while wb_stb is low");

    // a run only opens on the start byte
    busy_needs_start: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(rx_valid && rx_byte == start_byte))
        else $error("busy rose without a start byte");

endmodule

// sequencing checks on the controller, handshake checks on the bus slave
bind measure_ctrl echo_timer_assert ctrl_checks (
    .clk(clk), .rst(rst), .frame_start(frame_start), .run_done(run_done),
    .busy(busy), .rx_valid(rx_valid), .rx_byte(rx_byte),
    .wb_stb(1'b0), .wb_ack(1'b0)
);

bind wb_regs echo_timer_assert bus_checks (
    .clk(clk), .rst(rst), .frame_start(1'b0), .run_done(1'b0),
    .busy(1'b0), .rx_valid(1'b0), .rx_byte(8'h00),
    .wb_stb(wb_stb), .wb_ack(wb_ack)
);

//--- tb/tb_echo_timer.sv
`timescale 1ns/100ps

module tb_echo_timer import echo_pkg::*, bus_pkg::*; ();

    localparam int run_cycles = frame_len * frames_per_run;

    logic    clk;
    logic    rst;
    logic    uart_rxd;
    logic    echo_in;
    logic    tx_out;
    logic    wb_cyc;
    logic    wb_stb;
    logic    wb_we;
    wb_adr_t wb_adr;
    wb_dat_t wb_dat_w;
    wb_dat_t wb_dat_r;
    logic    wb_ack;

    bit wave [run_cycles];   // echo level per run cycle
    int rise_at [$];         // run cycles where a pulse starts
    int runs_expected;

    echo_timer_top echo_timer_top_inst (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;   // inputs move clear of the edge
    endtask

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] b);
        uart_rxd = 1'b0;
        step_cycles(clks_per_bit);
        for (int i = 0; i < 8; i++) begin
            uart_rxd = b[i];
            step_cycles(clks_per_bit);
        end
        uart_rxd = 1'b1;
        step_cycles(clks_per_bit);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t data);
        int t;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        t = 0;
        do begin
            step_cycles(1);
            t++;
            if (t > 20) stop_with_failure("no Wishbone ack within 20 cycles");
        end while (!wb_ack);
        data = wb_dat_r;
        step_cycles(1);   // master drops stb after the edge that sees ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wait_tx_rise();
        int t;
        t = 0;
        while (!tx_out) begin
            step_cycles(1);
            t++;
            if (t > 400) stop_with_failure("tx_out did not rise after the start byte");
        end
    endtask

    task automatic put_pulse(input int p);
        wave[p]     = 1'b1;
        wave[p + 1] = 1'b1;
        rise_at.push_back(p);
    endtask

    // sparse runs get empty frames and pulses that land in the burst
    task automatic build_wave(input bit sparse);
        int d;
        int base;
        int cnt;
        int cursor;
        foreach (wave[i]) wave[i] = 1'b0;
        rise_at.delete();
        for (int f = 0; f < frames_per_run; f++) begin
            base   = f * frame_len;
            cursor = 0;
            if (sparse) begin
                if (f % 3 == 1) continue;
                put_pulse(base + int'($urandom_range(0, 8)));
                if (f % 3 == 2) continue;
                cursor = 20;
            end
            cnt = int'($urandom_range(1, 3));
            for (int n = 0; n < cnt && cursor <= 245; n++) begin
                d = cursor + int'($urandom_range(0, 70));
                if (d > 245) d = 245;
                put_pulse(base + d);
                cursor = d + 6;
            end
        end
    endtask

    function automatic result_t expected_result(input int rises [$]);
        int        first [frames_per_run];
        int        last [frames_per_run];
        int        p;
        int        f;
        edge_sum_t bsum;
        edge_sum_t esum;
        foreach (first[i]) first[i] = -1;
        bsum = '0;
        esum = '0;
        foreach (rises[n]) begin
            p = rises[n] + 3;                           // sync and edge register
            if (p >= run_cycles) continue;              // past the last frame
            f = p / frame_len;
            if (p % frame_len < burst_len) continue;    // hidden by the burst
            if (first[f] < 0) first[f] = p % frame_len;
            last[f] = p % frame_len;
        end
        for (int i = 0; i < frames_per_run; i++) begin
            if (first[i] >= 0) begin
                bsum = bsum + edge_sum_t'(first[i]);
                esum = esum + edge_sum_t'(last[i]);
            end
        end
        return {bsum, esum};
    endfunction

    // entered in run cycle 0, plays the echo wave and watches tx_out
    task automatic drive_run();
        for (int i = 0; i < run_cycles; i++) begin
            if (i != 0) step_cycles(1);
            echo_in = wave[i];
            check("tx_out", 32'(tx_out), 32'((i % frame_len) < burst_len));
        end
    endtask

    task automatic measure_run(input bit sparse, input bit extra_start);
        wb_dat_t data;
        int      t;
        build_wave(sparse);
        fork
            send_byte(start_byte);
            begin
                wait_tx_rise();
                fork
                    drive_run();
                    if (extra_start) begin
                        step_cycles(300);
                        send_byte(start_byte);   // must not restart the run
                    end
                join
            end
        join
        runs_expected++;
        t = 0;
        do begin
            wb_read(reg_status, data);
            t++;
            if (t > 50) stop_with_failure("done did not set after the run");
        end while (data[1] != 1'b1);
        check("reg_status", data, 32'h2);
        wb_read(reg_result, data);
        check("reg_result", data, 32'(expected_result(rise_at)));
        wb_read(reg_runs, data);
        check("reg_runs", data, 32'(runs_expected));
    endtask

    initial begin
        wb_dat_t data;
        rst           = 1'b1;
        uart_rxd      = 1'b1;
        echo_in       = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        runs_expected = 0;
        void'($urandom(8737));
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
        step_cycles(2);

        wb_read(reg_id, data);
        check("reg_id", data, 32'hEC40_0001);
        wb_read(reg_status, data);
        check("reg_status", data, 32'h0);
        wb_read(reg_result, data);
        check("reg_result", data, 32'h0);
        wb_read(reg_runs, data);
        check("reg_runs", data, 32'h0);

        send_byte(8'h41);   // not the start byte
        for (int i = 0; i < 3000; i++) begin
            check("tx_out", 32'(tx_out), 32'h0);
            step_cycles(1);
        end
        wb_read(reg_status, data);
        check("reg_status", data, 32'h0);

        measure_run(1'b0, 1'b0);
        measure_run(1'b1, 1'b0);
        measure_run(1'b0, 1'b1);
        measure_run(1'b1, 1'b0);   // straight after the previous run

        $display("RESULT: PASS");
        $finish;
    end

endmodule
